//--- sim.f
+incdir+hdl
hdl/na_pkg.sv
hdl/noc_buffer.sv
hdl/noc_demux.sv
hdl/noc_mux.sv
hdl/wb_decode.sv
hdl/na_conf.sv
hdl/mpbuffer_wb.sv
hdl/na_ct_top.sv
tb/na_sva.sv
tb/na_tb.sv

//--- Bender.yml
package:
  name: na_ct

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/na_pkg.sv
      - hdl/noc_buffer.sv
      - hdl/noc_demux.sv
      - hdl/noc_mux.sv
      - hdl/wb_decode.sv
      - hdl/na_conf.sv
      - hdl/mpbuffer_wb.sv
      - hdl/na_ct_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/na_sva.sv
      - tb/na_tb.sv

//--- tb/na_tb.sv
/*
 * Table-driven testbench for na_ct_top with TILEID 3.
 * Bus accesses, NoC injections and expected output flits come from one
 * table. noc_out_ready_i is random for the whole run (xorshift, seed 16006).
 * Expected noc_out flits must be queued before the access that sends them.
 * The run stops after 40 cycles per table entry at most.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module na_tb;
   import na_pkg::*;

   localparam logic [2:0] OP_WR    = 3'd0;
   localparam logic [2:0] OP_RD    = 3'd1;
   localparam logic [2:0] OP_INJ   = 3'd2;
   localparam logic [2:0] OP_EXP   = 3'd3;
   localparam logic [2:0] OP_IRQ   = 3'd4;
   localparam logic [2:0] OP_IDLE  = 3'd5;
   localparam logic [2:0] OP_DRAIN = 3'd6;

   // dat holds a whole flit for inject and expect; exp is the idle length for idle
   typedef struct packed {
      logic [2:0]  op;
      logic [31:0] adr;
      logic [32:0] dat;
      logic [31:0] exp;
      logic        err;
   } entry_t;

   logic        clk;
   logic        rst_n_i;
   na_flit_t    noc_in_flit_i;
   logic        noc_in_valid_i;
   logic        noc_in_ready_o;
   na_flit_t    noc_out_flit_o;
   logic        noc_out_valid_o;
   logic        noc_out_ready_i;
   logic [31:0] wbs_adr_i;
   logic [31:0] wbs_dat_i;
   logic        wbs_cyc_i;
   logic        wbs_stb_i;
   logic        wbs_we_i;
   logic        wbs_ack_o;
   logic        wbs_err_o;
   logic [31:0] wbs_dat_o;
   logic        irq_o;

   entry_t      tbl[$];
   logic [32:0] exp_q[$];
   logic [31:0] rnd_state = 32'd16006;
   int unsigned mismatches = 0;
   int unsigned other_errors = 0;
   int unsigned cycle_count = 0;
   int unsigned cycle_limit = 0;

   na_ct_top #(.TILEID(5'd3)) DUT (.*);

   function automatic logic [31:0] make_hdr(input logic [4:0] dest, input logic [2:0] cls,
                                            input logic [4:0] src);
      return {dest, cls, src, 19'd0};
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic add_entry(input logic [2:0] op, input logic [31:0] adr,
                            input logic [32:0] dat, input logic [31:0] exp, input logic err);
      tbl.push_back('{op, adr, dat, exp, err});
   endtask

   task automatic check_value(input string name, input logic [32:0] got,
                              input logic [32:0] want);
      if (got !== want) begin
         mismatches++;
         $display("Fail at %0t: %s = %h, expected %h", $time, name, got, want);
      end
   endtask

   task automatic report_error(input string msg);
      other_errors++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic finish_run();
      int unsigned sva_fails;
      sva_fails = DUT.u_sva.fail_cnt;
      $display("Value mismatches: %0d, other errors: %0d, assertion failures: %0d",
               mismatches, other_errors, sva_fails);
      if (mismatches == 0 && other_errors == 0 && sva_fails == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   // Strobe held until ack or err, sampled on the falling edge
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [31:0] want, input logic want_err);
      int waited;
      @(negedge clk);
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      wbs_we_i  = we;
      wbs_adr_i = adr;
      wbs_dat_i = dat;
      waited    = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wbs_ack_o && !wbs_err_o && waited < 8);
      if (!wbs_ack_o && !wbs_err_o) begin
         report_error($sformatf("no bus response at address %h", adr));
      end else begin
         if (waited != 1) begin
            report_error($sformatf("bus response after %0d cycles", waited));
         end
         check_value("wbs_err_o", wbs_err_o, want_err);
         check_value("wbs_ack_o", wbs_ack_o, !want_err);
         if (!we && !want_err) begin
            check_value("wbs_dat_o", wbs_dat_o, want);
         end
      end
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
   endtask

   // Ready is stable at the falling edge, so the flit moves at the next rising edge
   task automatic inject_flit(input logic [32:0] f);
      int waited;
      @(negedge clk);
      noc_in_flit_i  = f;
      noc_in_valid_i = 1'b1;
      waited = 0;
      while (!noc_in_ready_o && waited < 50) begin
         @(negedge clk);
         waited++;
      end
      if (!noc_in_ready_o) begin
         report_error("noc_in never became ready");
      end
      @(negedge clk);
      noc_in_valid_i = 1'b0;
   endtask

   task automatic drain_output();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 400) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         report_error($sformatf("%0d expected noc_out flits never arrived", exp_q.size()));
         exp_q.delete();
      end
      // Quiet window in which any extra flit is flagged
      repeat (10) @(negedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random ready on the output side, and the flit that will move is checked in order
   always @(negedge clk) begin
      if (rst_n_i) begin
         rnd_state = xorshift(rnd_state);
         noc_out_ready_i = (rnd_state[1:0] != 2'b00);
         if (noc_out_valid_o && noc_out_ready_i) begin
            if (exp_q.size() == 0) begin
               report_error($sformatf("unexpected flit %h on noc_out", noc_out_flit_o));
            end else begin
               check_value("noc_out_flit_o", noc_out_flit_o, exp_q.pop_front());
            end
         end
      end
   end

   initial begin
      wait (cycle_limit != 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      report_error($sformatf("timeout after %0d cycles, table not finished", cycle_count));
      finish_run();
   end

   initial begin
      entry_t e;
      rst_n_i         = 1'b0;
      noc_in_flit_i   = '0;
      noc_in_valid_i  = 1'b0;
      noc_out_ready_i = 1'b0;
      wbs_adr_i       = '0;
      wbs_dat_i       = '0;
      wbs_cyc_i       = 1'b0;
      wbs_stb_i       = 1'b0;
      wbs_we_i        = 1'b0;

      // Configuration block
      add_entry(OP_IRQ, 0, 0, 0, 0);
      add_entry(OP_RD, 32'h0000_0000, 0, 32'd3, 0);
      add_entry(OP_RD, 32'h0000_0004, 0, 32'd16, 0);
      add_entry(OP_WR, 32'h0000_0008, 33'hA5A5_0001, 0, 0);
      add_entry(OP_RD, 32'h0000_0008, 0, 32'hA5A5_0001, 0);
      add_entry(OP_WR, 32'h0000_0000, 33'h0000_1234, 0, 0);
      add_entry(OP_RD, 32'h0000_0000, 0, 32'd3, 0);
      add_entry(OP_RD, 32'h0030_0000, 0, 0, 1);
      add_entry(OP_WR, 32'h0020_0010, 33'h1, 0, 1);
      // Three words sent with the last one through 0x4
      add_entry(OP_EXP, 0, {1'b0, make_hdr(5'd5, `NA_CLS_MP, 5'd3)}, 0, 0);
      add_entry(OP_EXP, 0, {1'b0, 32'hCAFE_0001}, 0, 0);
      add_entry(OP_EXP, 0, {1'b1, 32'hCAFE_0002}, 0, 0);
      add_entry(OP_WR, 32'h0010_0000, {1'b0, make_hdr(5'd5, `NA_CLS_MP, 5'd3)}, 0, 0);
      add_entry(OP_WR, 32'h0010_0000, 33'hCAFE_0001, 0, 0);
      add_entry(OP_WR, 32'h0010_0004, 33'hCAFE_0002, 0, 0);
      add_entry(OP_DRAIN, 0, 0, 0, 0);
      // Receive path
      add_entry(OP_INJ, 0, {1'b0, make_hdr(5'd3, `NA_CLS_MP, 5'd7)}, 0, 0);
      add_entry(OP_INJ, 0, {1'b0, 32'h0000_0011}, 0, 0);
      add_entry(OP_INJ, 0, {1'b1, 32'h0000_0022}, 0, 0);
      add_entry(OP_IDLE, 0, 0, 4, 0);
      add_entry(OP_IRQ, 0, 0, 1, 0);
      add_entry(OP_RD, 32'h0010_0004, 0, 32'd3, 0);
      add_entry(OP_RD, 32'h0010_0000, 0, make_hdr(5'd3, `NA_CLS_MP, 5'd7), 0);
      add_entry(OP_RD, 32'h0010_0000, 0, 32'h0000_0011, 0);
      add_entry(OP_RD, 32'h0010_0000, 0, 32'h0000_0022, 0);
      add_entry(OP_IRQ, 0, 0, 0, 0);
      add_entry(OP_RD, 32'h0010_0004, 0, 32'h8000_0000, 0);
      add_entry(OP_RD, 32'h0010_0000, 0, 0, 1);
      // Ping from tile 7
      add_entry(OP_EXP, 0, {1'b0, make_hdr(5'd7, `NA_CLS_PING, 5'd3)}, 0, 0);
      add_entry(OP_EXP, 0, {1'b1, 32'hA5A5_0001}, 0, 0);
      add_entry(OP_INJ, 0, {1'b1, make_hdr(5'd3, `NA_CLS_PING, 5'd7)}, 0, 0);
      add_entry(OP_DRAIN, 0, 0, 0, 0);
      // Class 5 is dropped but the next message still arrives
      add_entry(OP_INJ, 0, {1'b0, make_hdr(5'd3, 3'd5, 5'd7)}, 0, 0);
      add_entry(OP_INJ, 0, {1'b1, 32'h0000_0055}, 0, 0);
      add_entry(OP_IDLE, 0, 0, 6, 0);
      add_entry(OP_IRQ, 0, 0, 0, 0);
      add_entry(OP_DRAIN, 0, 0, 0, 0);
      add_entry(OP_INJ, 0, {1'b0, make_hdr(5'd3, `NA_CLS_MP, 5'd9)}, 0, 0);
      add_entry(OP_INJ, 0, {1'b1, 32'h0000_0066}, 0, 0);
      add_entry(OP_IDLE, 0, 0, 4, 0);
      add_entry(OP_IRQ, 0, 0, 1, 0);
      add_entry(OP_RD, 32'h0010_0004, 0, 32'h8000_0002, 0);
      add_entry(OP_RD, 32'h0010_0000, 0, make_hdr(5'd3, `NA_CLS_MP, 5'd9), 0);
      add_entry(OP_RD, 32'h0010_0000, 0, 32'h0000_0066, 0);
      add_entry(OP_RD, 32'h0010_0004, 0, 32'h8000_0000, 0);
      add_entry(OP_IRQ, 0, 0, 0, 0);
      // Ping arriving in the middle of an outgoing message
      add_entry(OP_WR, 32'h0000_0008, 33'h600D_0006, 0, 0);
      add_entry(OP_EXP, 0, {1'b0, make_hdr(5'd9, `NA_CLS_MP, 5'd3)}, 0, 0);
      add_entry(OP_EXP, 0, {1'b0, 32'h0000_0061}, 0, 0);
      add_entry(OP_EXP, 0, {1'b1, 32'h0000_0062}, 0, 0);
      add_entry(OP_EXP, 0, {1'b0, make_hdr(5'd7, `NA_CLS_PING, 5'd3)}, 0, 0);
      add_entry(OP_EXP, 0, {1'b1, 32'h600D_0006}, 0, 0);
      add_entry(OP_WR, 32'h0010_0000, {1'b0, make_hdr(5'd9, `NA_CLS_MP, 5'd3)}, 0, 0);
      add_entry(OP_WR, 32'h0010_0000, 33'h0000_0061, 0, 0);
      add_entry(OP_INJ, 0, {1'b1, make_hdr(5'd3, `NA_CLS_PING, 5'd7)}, 0, 0);
      add_entry(OP_IDLE, 0, 0, 8, 0);
      add_entry(OP_WR, 32'h0010_0004, 33'h0000_0062, 0, 0);
      add_entry(OP_DRAIN, 0, 0, 0, 0);
      cycle_limit = 2 * tbl.size() * 20;

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      check_value("noc_out_valid_o", noc_out_valid_o, 0);
      check_value("wbs_ack_o", wbs_ack_o, 0);
      check_value("wbs_err_o", wbs_err_o, 0);
      check_value("irq_o", irq_o, 0);

      foreach (tbl[i]) begin
         e = tbl[i];
         case (e.op)
            OP_WR:   bus_access(1'b1, e.adr, e.dat[31:0], '0, e.err);
            OP_RD:   bus_access(1'b0, e.adr, '0, e.exp, e.err);
            OP_INJ:  inject_flit(e.dat);
            OP_EXP:  exp_q.push_back(e.dat);
            OP_IRQ: begin
               @(negedge clk);
               check_value("irq_o", irq_o, e.exp[0]);
            end
            OP_IDLE: repeat (e.exp) @(negedge clk);
            default: drain_output();
         endcase
      end
      finish_run();
   end

endmodule

//--- tb/na_sva.sv
/*
 * Handshake assertions on the outer ports of na_ct_top, bound into
 * every instance. fail_cnt holds the number of assertion failures so
 * that the enclosing testbench can include it in its result.
 */
`timescale 1ns/1ps

module na_sva (
   input logic             clk,
   input logic             rst_n_i,
   input na_pkg::na_flit_t out_flit_i,
   input logic             out_valid_i,
   input logic             out_ready_i,
   input logic             ack_i,
   input logic             err_i
);
   int unsigned fail_cnt = 0;

   // A stalled flit stays offered and unchanged
   a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
   else begin
      fail_cnt++;
      $error("noc_out flit changed or dropped while stalled");
   end

   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ack_i && err_i))
   else begin
      fail_cnt++;
      $error("wbs_ack_o and wbs_err_o high together");
   end

   // Responses are single-cycle pulses
   a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i)
   else begin
      fail_cnt++;
      $error("wbs_ack_o longer than one cycle");
   end

   a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) err_i |=> !err_i)
   else begin
      fail_cnt++;
      $error("wbs_err_o longer than one cycle");
   end

endmodule

bind na_ct_top na_sva u_sva (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .out_flit_i  (noc_out_flit_o),
   .out_valid_i (noc_out_valid_o),
   .out_ready_i (noc_out_ready_i),
   .ack_i       (wbs_ack_o),
   .err_i       (wbs_err_o)
);

//--- hdl/na_ct_top.sv
/*
 * Network adapter for a compute tile, one NoC channel each way.
 * Inbound packets go to the message queue or the ping responder by
 * class, unknown classes are dropped. Outbound, message packets and
 * ping replies share the channel packet by packet.
 * Bus map on bits 23:20: 0 configuration, 1 message buffer.
 * irq_o is high while received words are waiting.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module na_ct_top #(
   parameter logic [4:0] TILEID = 5'd3
) (
   input  logic             clk,
   input  logic             rst_n_i,
   input  na_pkg::na_flit_t noc_in_flit_i,
   input  logic             noc_in_valid_i,
   output logic             noc_in_ready_o,
   output na_pkg::na_flit_t noc_out_flit_o,
   output logic             noc_out_valid_o,
   input  logic             noc_out_ready_i,
   input  logic [31:0]      wbs_adr_i,
   input  logic [31:0]      wbs_dat_i,
   input  logic             wbs_cyc_i,
   input  logic             wbs_stb_i,
   input  logic             wbs_we_i,
   output logic             wbs_ack_o,
   output logic             wbs_err_o,
   output logic [31:0]      wbs_dat_o,
   output logic             irq_o
);
   import na_pkg::*;

   na_flit_t    in_flit, rx_flit, ping_flit, tx_flit, rep_flit, mux_flit;
   logic        in_valid, rx_valid, ping_valid, tx_valid, rep_valid, mux_valid;
   logic        in_ready, rx_ready, ping_ready, tx_ready, rep_ready, mux_ready;
   na_bus_req_t conf_req, mp_req;
   logic        conf_ack, mp_ack, mp_err;
   logic [31:0] conf_dat, mp_dat;

   noc_buffer #(.DEPTH(`NA_FLIT_DEPTH)) u_inbuf (
      .clk, .rst_n_i,
      .in_flit_i (noc_in_flit_i), .in_valid_i (noc_in_valid_i), .in_ready_o (noc_in_ready_o),
      .out_flit_o (in_flit), .out_valid_o (in_valid), .out_ready_i (in_ready)
   );

   noc_demux u_demux (
      .clk, .rst_n_i,
      .in_flit_i (in_flit), .in_valid_i (in_valid), .in_ready_o (in_ready),
      .mp_flit_o (rx_flit), .mp_valid_o (rx_valid), .mp_ready_i (rx_ready),
      .ping_flit_o (ping_flit), .ping_valid_o (ping_valid), .ping_ready_i (ping_ready)
   );

   wb_decode u_decode (
      .clk, .rst_n_i,
      .wbs_adr_i, .wbs_dat_i, .wbs_cyc_i, .wbs_stb_i, .wbs_we_i,
      .wbs_ack_o, .wbs_err_o, .wbs_dat_o,
      .conf_req_o (conf_req), .mp_req_o (mp_req),
      .conf_ack_i (conf_ack), .conf_dat_i (conf_dat),
      .mp_ack_i (mp_ack), .mp_err_i (mp_err), .mp_dat_i (mp_dat)
   );

   na_conf #(.TILEID(TILEID)) u_conf (
      .clk, .rst_n_i,
      .req_i (conf_req), .ack_o (conf_ack), .dat_o (conf_dat),
      .ping_flit_i (ping_flit), .ping_valid_i (ping_valid), .ping_ready_o (ping_ready),
      .rep_flit_o (rep_flit), .rep_valid_o (rep_valid), .rep_ready_i (rep_ready)
   );

   mpbuffer_wb u_mpbuf (
      .clk, .rst_n_i,
      .req_i (mp_req), .ack_o (mp_ack), .err_o (mp_err), .dat_o (mp_dat),
      .rx_flit_i (rx_flit), .rx_valid_i (rx_valid), .rx_ready_o (rx_ready),
      .tx_flit_o (tx_flit), .tx_valid_o (tx_valid), .tx_ready_i (tx_ready),
      .irq_o
   );

   noc_mux u_mux (
      .clk, .rst_n_i,
      .in0_flit_i (tx_flit), .in0_valid_i (tx_valid), .in0_ready_o (tx_ready),
      .in1_flit_i (rep_flit), .in1_valid_i (rep_valid), .in1_ready_o (rep_ready),
      .out_flit_o (mux_flit), .out_valid_o (mux_valid), .out_ready_i (mux_ready)
   );

   noc_buffer #(.DEPTH(`NA_FLIT_DEPTH)) u_outbuf (
      .clk, .rst_n_i,
      .in_flit_i (mux_flit), .in_valid_i (mux_valid), .in_ready_o (mux_ready),
      .out_flit_o (noc_out_flit_o), .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

endmodule

//--- hdl/mpbuffer_wb.sv
/*
 * Message passing buffer with a send and a receive flit queue.
 * Write 0x0 queues a word, write 0x4 queues the word that ends the
 * packet; the first word of a packet must be a valid header.
 * Read 0x0 pops a received word, read 0x4 gives the receive count with
 * bit 31 showing whether the last popped word ended its packet.
 * A write to a full send queue or a pop from an empty receive queue
 * answers with err and has no effect.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module mpbuffer_wb (
   input  logic                clk,
   input  logic                rst_n_i,
   input  na_pkg::na_bus_req_t req_i,
   output logic                ack_o,
   output logic                err_o,
   output logic [31:0]         dat_o,
   input  na_pkg::na_flit_t    rx_flit_i,
   input  logic                rx_valid_i,
   output logic                rx_ready_o,
   output na_pkg::na_flit_t    tx_flit_o,
   output logic                tx_valid_o,
   input  logic                tx_ready_i,
   output logic                irq_o
);
   import na_pkg::*;

   localparam int CW = $clog2(`NA_MP_SIZE + 1);

   na_flit_t      txq_flit;
   logic          txq_ready;
   na_flit_t      rxq_flit;
   logic          rxq_valid;
   logic          wr_tx;
   logic          rd_rx;
   logic          bad_acc;
   logic          rx_push;
   logic          rx_pop;
   logic [CW-1:0] rx_cnt;
   logic          last_q;

   assign wr_tx    = req_i.stb & req_i.we & (req_i.adr == 8'h00 || req_i.adr == 8'h04);
   assign rd_rx    = req_i.stb & ~req_i.we & (req_i.adr == 8'h00);
   assign bad_acc  = (wr_tx & ~txq_ready) | (rd_rx & ~rxq_valid);
   assign rx_push  = rx_valid_i & rx_ready_o;
   assign rx_pop   = rd_rx & rxq_valid;
   assign txq_flit = {req_i.adr[2], req_i.dat};
   assign irq_o    = (rx_cnt != '0);

   noc_buffer #(
      .DEPTH(`NA_MP_SIZE)
   ) u_txq (
      .clk,
      .rst_n_i,
      .in_flit_i   (txq_flit),
      .in_valid_i  (wr_tx),
      .in_ready_o  (txq_ready),
      .out_flit_o  (tx_flit_o),
      .out_valid_o (tx_valid_o),
      .out_ready_i (tx_ready_i)
   );

   noc_buffer #(
      .DEPTH(`NA_MP_SIZE)
   ) u_rxq (
      .clk,
      .rst_n_i,
      .in_flit_i   (rx_flit_i),
      .in_valid_i  (rx_valid_i),
      .in_ready_o  (rx_ready_o),
      .out_flit_o  (rxq_flit),
      .out_valid_o (rxq_valid),
      .out_ready_i (rd_rx)
   );

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o  <= 1'b0;
         err_o  <= 1'b0;
         rx_cnt <= '0;
         last_q <= 1'b0;
      end else begin
         ack_o  <= req_i.stb & ~bad_acc;
         err_o  <= bad_acc;
         rx_cnt <= rx_cnt + CW'(rx_push) - CW'(rx_pop);
         if (rx_pop) begin
            last_q <= rxq_flit.last;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_i.stb) begin
         if (rd_rx) begin
            dat_o <= rxq_flit.word.raw;
         end else if (req_i.adr == 8'h04) begin
            dat_o <= {last_q, {(31 - CW){1'b0}}, rx_cnt};
         end else begin
            dat_o <= '0;
         end
      end
   end

endmodule

//--- hdl/na_conf.sv
/*
 * Configuration registers and ping responder.
 * Offsets 0x0 (tile id) and 0x4 (queue size) are read only, 0x8 is a
 * scratch register; other offsets read zero.
 * A ping is answered with a header back to its source and one last
 * flit holding the scratch value. Further pings wait until the reply
 * has left.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module na_conf #(
   parameter logic [4:0] TILEID = 5'd3
) (
   input  logic                clk,
   input  logic                rst_n_i,
   input  na_pkg::na_bus_req_t req_i,
   output logic                ack_o,
   output logic [31:0]         dat_o,
   input  na_pkg::na_flit_t    ping_flit_i,
   input  logic                ping_valid_i,
   output logic                ping_ready_o,
   output na_pkg::na_flit_t    rep_flit_o,
   output logic                rep_valid_o,
   input  logic                rep_ready_i
);
   import na_pkg::*;

   localparam logic [1:0] R_IDLE = 2'd0;
   localparam logic [1:0] R_HDR  = 2'd1;
   localparam logic [1:0] R_TAIL = 2'd2;

   logic [31:0] scratch_q;
   logic [4:0]  dest_q;
   logic        in_pkt_q;
   logic [1:0]  rep_q;
   logic        ping_fire;
   na_hdr_t     rep_hdr;

   assign ping_ready_o = (rep_q == R_IDLE);
   assign ping_fire    = ping_valid_i & ping_ready_o;
   assign rep_valid_o  = (rep_q != R_IDLE);
   assign rep_hdr      = '{dest: dest_q, cls: `NA_CLS_PING, src: TILEID, rsvd: '0};

   // Same word is a header first, then raw payload
   always_comb begin
      rep_flit_o.last = (rep_q == R_TAIL);
      if (rep_q == R_TAIL) begin
         rep_flit_o.word.raw = scratch_q;
      end else begin
         rep_flit_o.word.hdr = rep_hdr;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o     <= 1'b0;
         scratch_q <= '0;
         in_pkt_q  <= 1'b0;
         rep_q     <= R_IDLE;
      end else begin
         ack_o <= req_i.stb;
         if (req_i.stb && req_i.we && req_i.adr == 8'h08) begin
            scratch_q <= req_i.dat;
         end
         if (ping_fire) begin
            in_pkt_q <= ~ping_flit_i.last;
         end
         case (rep_q)
            R_IDLE:  if (ping_fire && ping_flit_i.last) rep_q <= R_HDR;
            R_HDR:   if (rep_ready_i) rep_q <= R_TAIL;
            default: if (rep_ready_i) rep_q <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      // Source of the ping header becomes the reply destination
      if (ping_fire && !in_pkt_q) begin
         dest_q <= ping_flit_i.word.hdr.src;
      end
      if (req_i.stb) begin
         case (req_i.adr)
            8'h00:   dat_o <= {27'd0, TILEID};
            8'h04:   dat_o <= 32'(`NA_MP_SIZE);
            8'h08:   dat_o <= scratch_q;
            default: dat_o <= '0;
         endcase
      end
   end

endmodule

//--- hdl/wb_decode.sv
/*
 * Bus slave address decoder. Address bits 23:20 select the slave,
 * bits 7:0 are passed on as the offset; bits 19:8 are not decoded.
 * Slaves answer one cycle after their strobe. An unmapped access gets
 * an error from here after the same delay. The strobe is blocked in the
 * response cycle so that a held strobe is not taken as a new access.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module wb_decode (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic [31:0]         wbs_adr_i,
   input  logic [31:0]         wbs_dat_i,
   input  logic                wbs_cyc_i,
   input  logic                wbs_stb_i,
   input  logic                wbs_we_i,
   output logic                wbs_ack_o,
   output logic                wbs_err_o,
   output logic [31:0]         wbs_dat_o,
   output na_pkg::na_bus_req_t conf_req_o,
   output na_pkg::na_bus_req_t mp_req_o,
   input  logic                conf_ack_i,
   input  logic [31:0]         conf_dat_i,
   input  logic                mp_ack_i,
   input  logic                mp_err_i,
   input  logic [31:0]         mp_dat_i
);
   logic [3:0] sel;
   logic       go;
   logic       hit_conf;
   logic       hit_mp;
   logic       pend_q;
   logic       unmap_q;

   assign sel      = wbs_adr_i[23:20];
   assign go       = wbs_cyc_i & wbs_stb_i & ~pend_q;
   assign hit_conf = (sel == `NA_SEL_CONF);
   assign hit_mp   = (sel == `NA_SEL_MP);

   assign conf_req_o = '{stb: go & hit_conf, we: wbs_we_i, adr: wbs_adr_i[7:0],
                         dat: wbs_dat_i};
   assign mp_req_o   = '{stb: go & hit_mp, we: wbs_we_i, adr: wbs_adr_i[7:0],
                         dat: wbs_dat_i};

   // Responses merged, data from whichever slave acks
   assign wbs_ack_o = conf_ack_i | mp_ack_i;
   assign wbs_err_o = unmap_q | mp_err_i;
   assign wbs_dat_o = conf_ack_i ? conf_dat_i : mp_dat_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q  <= 1'b0;
         unmap_q <= 1'b0;
      end else begin
         pend_q  <= go;
         unmap_q <= go & ~hit_conf & ~hit_mp;
      end
   end

endmodule

//--- hdl/noc_mux.sv
/*
 * Two-input packet multiplexer with round-robin arbitration.
 * The grant is taken when a flit is first offered and is held until the
 * last flit of that packet has been transferred, so packets never
 * interleave and an offered flit stays stable under back-pressure.
 */
`timescale 1ns/1ps

module noc_mux (
   input  logic             clk,
   input  logic             rst_n_i,
   input  na_pkg::na_flit_t in0_flit_i,
   input  logic             in0_valid_i,
   output logic             in0_ready_o,
   input  na_pkg::na_flit_t in1_flit_i,
   input  logic             in1_valid_i,
   output logic             in1_ready_o,
   output na_pkg::na_flit_t out_flit_o,
   output logic             out_valid_o,
   input  logic             out_ready_i
);
   logic hold_q;
   logic gnt_q;
   logic prio_q;
   logic pick;
   logic gnt;
   logic done;

   // Tie goes to prio_q, otherwise whichever input is valid
   assign pick = (in0_valid_i & in1_valid_i) ? prio_q : in1_valid_i;
   assign gnt  = hold_q ? gnt_q : pick;

   assign out_flit_o  = gnt ? in1_flit_i : in0_flit_i;
   assign out_valid_o = gnt ? in1_valid_i : in0_valid_i;
   assign in0_ready_o = ~gnt & out_ready_i;
   assign in1_ready_o = gnt & out_ready_i;
   assign done        = out_valid_o & out_ready_i & out_flit_o.last;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_q <= 1'b0;
         gnt_q  <= 1'b0;
         prio_q <= 1'b0;
      end else begin
         if (out_valid_o) begin
            gnt_q  <= gnt;
            hold_q <= ~done;
         end
         // other side wins the next tie
         if (done) begin
            prio_q <= ~gnt;
         end
      end
   end

endmodule

//--- hdl/noc_demux.sv
/*
 * Inbound packet router. The class of the header flit selects the
 * message queue, the ping responder, or a drop state in which the
 * packet is accepted and discarded.
 * Paths are combinational; the selection holds until the last flit.
 */
`timescale 1ns/1ps
`include "na_consts.svh"

module noc_demux (
   input  logic             clk,
   input  logic             rst_n_i,
   input  na_pkg::na_flit_t in_flit_i,
   input  logic             in_valid_i,
   output logic             in_ready_o,
   output na_pkg::na_flit_t mp_flit_o,
   output logic             mp_valid_o,
   input  logic             mp_ready_i,
   output na_pkg::na_flit_t ping_flit_o,
   output logic             ping_valid_o,
   input  logic             ping_ready_i
);
   localparam logic [1:0] T_MP   = 2'd0;
   localparam logic [1:0] T_PING = 2'd1;
   localparam logic [1:0] T_DROP = 2'd2;

   logic       busy_q;
   logic [1:0] tgt_q;
   logic [1:0] hdr_tgt;
   logic [1:0] tgt;

   // Only meaningful on a header flit
   always_comb begin
      case (in_flit_i.word.hdr.cls)
         `NA_CLS_MP:   hdr_tgt = T_MP;
         `NA_CLS_PING: hdr_tgt = T_PING;
         default:      hdr_tgt = T_DROP;
      endcase
   end

   assign tgt          = busy_q ? tgt_q : hdr_tgt;
   assign mp_flit_o    = in_flit_i;
   assign ping_flit_o  = in_flit_i;
   assign mp_valid_o   = in_valid_i & (tgt == T_MP);
   assign ping_valid_o = in_valid_i & (tgt == T_PING);
   assign in_ready_o   = (tgt == T_MP)   ? mp_ready_i :
                         (tgt == T_PING) ? ping_ready_i : 1'b1;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         tgt_q  <= T_MP;
      end else if (in_valid_i && in_ready_o) begin
         busy_q <= ~in_flit_i.last;
         tgt_q  <= tgt;
      end
   end

endmodule

//--- hdl/noc_buffer.sv
/*
 * Flit FIFO with valid/ready on both sides.
 * The output comes straight from the storage registers, so a flit
 * written into an empty buffer is visible one cycle later.
 * in_ready_o drops only when all DEPTH entries are in use.
 * DEPTH need not be a power of two.
 */
`timescale 1ns/1ps

module noc_buffer #(
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst_n_i,
   input  na_pkg::na_flit_t in_flit_i,
   input  logic             in_valid_i,
   output logic             in_ready_o,
   output na_pkg::na_flit_t out_flit_o,
   output logic             out_valid_o,
   input  logic             out_ready_i
);
   import na_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   na_flit_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;

   // Pointer increment with wrap at DEPTH
   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
      return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;
   assign in_ready_o  = (count != (AW+1)'(DEPTH));
   assign out_valid_o = (count != '0);
   assign out_flit_o  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_flit_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         count <= count + (AW+1)'(push) - (AW+1)'(pop);
      end
   end

endmodule

//--- hdl/na_pkg.sv
/*
 * Shared types of the compute tile network adapter.
 * A flit is 33 bits, a last marker and one 32-bit word. The word is
 * either raw payload or a header; only the first flit of a packet
 * carries a header.
 * Bus requests to the slaves carry an 8-bit offset only, so each slave
 * decodes at most 256 bytes of address space.
 */
package na_pkg;

   // Header layout, dest in the top bits
   typedef struct packed {
      logic [4:0]  dest;
      logic [2:0]  cls;
      logic [4:0]  src;
      logic [18:0] rsvd;
   } na_hdr_t;

   typedef union packed {
      logic [31:0] raw;
      na_hdr_t     hdr;
   } na_word_u;

   typedef struct packed {
      logic     last;
      na_word_u word;
   } na_flit_t;

   // One access from the address decoder to a slave
   typedef struct packed {
      logic        stb;
      logic        we;
      logic [7:0]  adr;
      logic [31:0] dat;
   } na_bus_req_t;

endpackage

//--- hdl/na_consts.svh
/*
 * Sizes, packet classes and slave select values of the network adapter.
 * The select values compare against bus address bits 23:20.
 * Only the classes listed here are delivered; all others are dropped.
 */
`ifndef NA_CONSTS_SVH
`define NA_CONSTS_SVH

// NoC input and output buffer depth
`define NA_FLIT_DEPTH 4
// Depth of each message queue, also read back by software
`define NA_MP_SIZE 16

`define NA_CLS_MP 3'd0
`define NA_CLS_PING 3'd1

`define NA_SEL_CONF 4'd0
`define NA_SEL_MP 4'd1

`endif
